/* include/quarter_sine_table.svh */
`ifndef QUARTER_SINE_TABLE_SVH
`define QUARTER_SINE_TABLE_SVH

// round(sin(d) * 2^14), d from 0 to 90 degrees.
localparam trig_pkg::table_word quarter_sine [trig_pkg::quarter_entries] = '{
	16'd0,
	16'd286,
	16'd572,
	16'd857,
	16'd1143,
	16'd1428,
	16'd1713,
	16'd1997,
	16'd2280,
	16'd2563,
	16'd2845,
	16'd3126,
	16'd3406,
	16'd3686,
	16'd3964,
	16'd4240,
	16'd4516,
	16'd4790,
	16'd5063,
	16'd5334,
	16'd5604,
	16'd5872,
	16'd6138,
	16'd6402,
	16'd6664,
	16'd6924,
	16'd7182,
	16'd7438,
	16'd7692,
	16'd7943,
	16'd8192,
	16'd8438,
	16'd8682,
	16'd8923,
	16'd9162,
	16'd9397,
	16'd9630,
	16'd9860,
	16'd10087,
	16'd10311,
	16'd10531,
	16'd10749,
	16'd10963,
	16'd11174,
	16'd11381,
	16'd11585,
	16'd11786,
	16'd11982,
	16'd12176,
	16'd12365,
	16'd12551,
	16'd12733,
	16'd12911,
	16'd13085,
	16'd13255,
	16'd13421,
	16'd13583,
	16'd13741,
	16'd13894,
	16'd14044,
	16'd14189,
	16'd14330,
	16'd14466,
	16'd14598,
	16'd14726,
	16'd14849,
	16'd14968,
	16'd15082,
	16'd15191,
	16'd15296,
	16'd15396,
	16'd15491,
	16'd15582,
	16'd15668,
	16'd15749,
	16'd15826,
	16'd15897,
	16'd15964,
	16'd16026,
	16'd16083,
	16'd16135,
	16'd16182,
	16'd16225,
	16'd16262,
	16'd16294,
	16'd16322,
	16'd16344,
	16'd16362,
	16'd16374,
	16'd16382,
	16'd16384
};

`endif

/* hw/fixed_pkg.sv */
package fixed_pkg;

	// signed 32.32.
	typedef logic signed [63:0] fixed_real;

	// packed as z, y, x from the top.
	typedef fixed_real [2:0] ray_vec;

	localparam int frac_shift = 32;

	localparam fixed_real one_degree = 64'sh0000_0001_0000_0000;
	localparam fixed_real full_turn = 64'sh0000_0168_0000_0000; // 360.0.

endpackage

/* hw/trig_pkg.sv */
package trig_pkg;

	typedef logic [8:0] deg_idx;

	// sign-magnitude, Q1.14 magnitude.
	typedef logic [15:0] table_word;

	typedef logic [1:0] weight_t; // quarter degrees.

	localparam int quarter_entries = 91;
	localparam int table_shift = 18; // Q1.14 magnitude into 32.32.

	// low words at the whole degree, high words one degree up.
	typedef struct packed {
		table_word sin_t0;
		table_word cos_t0;
		table_word sin_t1;
		table_word cos_t1;
		table_word sin_p0;
		table_word cos_p0;
		table_word sin_p1;
		table_word cos_p1;
		weight_t w_theta;
		weight_t w_phi;
	} trig_sample;

endpackage

/* hw/angle_lookup.sv */
`timescale 1ns/1ps

module angle_lookup (
	input  logic                 Clk,
	input  logic                 arst_n,
	input  logic                 in_valid,
	output logic                 in_ready,
	input  fixed_pkg::fixed_real theta,
	input  fixed_pkg::fixed_real phi,
	output logic                 s_valid,
	input  logic                 s_ready,
	output trig_pkg::trig_sample sample
);

`include "quarter_sine_table.svh"

function automatic fixed_pkg::fixed_real wrap(input fixed_pkg::fixed_real a);
	return a[63] ? a + fixed_pkg::full_turn : a;
endfunction

// whole degree above a, 359 rolls over to 0.
function automatic trig_pkg::deg_idx next_deg(input fixed_pkg::fixed_real a);
	fixed_pkg::fixed_real up;
	up = a + fixed_pkg::one_degree;
	return (up >= fixed_pkg::full_turn) ? '0 : up[40:32];
endfunction

function automatic trig_pkg::table_word sin_word(input trig_pkg::deg_idx d);
	trig_pkg::deg_idx m;
	logic neg;
	neg = (d > 9'd180);
	if (d <= 9'd90)
		m = d;
	else if (d <= 9'd180)
		m = 9'd180 - d; // mirror about 90.
	else if (d <= 9'd270)
		m = d - 9'd180;
	else
		m = 9'd360 - d;
	return {neg, quarter_sine[m[6:0]][14:0]};
endfunction

function automatic trig_pkg::table_word cos_word(input trig_pkg::deg_idx d);
	trig_pkg::deg_idx m;
	logic neg;
	neg = (d > 9'd90) && (d <= 9'd270);
	if (d <= 9'd90)
		m = 9'd90 - d;
	else if (d <= 9'd180)
		m = d - 9'd90;
	else if (d <= 9'd270)
		m = 9'd270 - d;
	else
		m = d - 9'd270;
	return {neg, quarter_sine[m[6:0]][14:0]};
endfunction

fixed_pkg::fixed_real theta_w;
fixed_pkg::fixed_real phi_w;
trig_pkg::deg_idx t0;
trig_pkg::deg_idx t1;
trig_pkg::deg_idx p0;
trig_pkg::deg_idx p1;
trig_pkg::trig_sample sample_d;

assign theta_w = wrap(theta);
assign phi_w = wrap(phi);
assign t0 = theta_w[40:32];
assign p0 = phi_w[40:32];
assign t1 = next_deg(theta_w);
assign p1 = next_deg(phi_w);

always_comb begin
	sample_d.sin_t0 = sin_word(t0);
	sample_d.cos_t0 = cos_word(t0);
	sample_d.sin_t1 = sin_word(t1);
	sample_d.cos_t1 = cos_word(t1);
	sample_d.sin_p0 = sin_word(p0);
	sample_d.cos_p0 = cos_word(p0);
	sample_d.sin_p1 = sin_word(p1);
	sample_d.cos_p1 = cos_word(p1);
	sample_d.w_theta = theta_w[31:30]; // finer fraction dropped.
	sample_d.w_phi = phi_w[31:30];
end

assign in_ready = !s_valid || s_ready;

always_ff @(posedge Clk or negedge arst_n) begin
	if (!arst_n)
		s_valid <= 1'b0;
	else if (in_ready)
		s_valid <= in_valid;
end

always_ff @(posedge Clk) begin
	if (in_valid && in_ready)
		sample <= sample_d;
end

// wrap only covers one turn.
a_angle_range: assert property (@(posedge Clk) disable iff (!arst_n)
	in_valid && in_ready |->
		theta > -fixed_pkg::full_turn && theta < fixed_pkg::full_turn &&
		phi > -fixed_pkg::full_turn && phi < fixed_pkg::full_turn);

endmodule

/* hw/sample_buffer.sv */
`timescale 1ns/1ps

module sample_buffer (
	input  logic                 Clk,
	input  logic                 arst_n,
	input  logic                 s_valid,
	output logic                 s_ready,
	input  trig_pkg::trig_sample sample,
	output logic                 b_valid,
	input  logic                 b_ready,
	output trig_pkg::trig_sample held
);

trig_pkg::trig_sample slots [2];
logic rd_ptr;
logic wr_ptr;
logic [1:0] count;
logic wr_en;
logic rd_en;

assign s_ready = count < 2'd2;
assign b_valid = count != 2'd0;
assign wr_en = s_valid && s_ready;
assign rd_en = b_valid && b_ready;
assign held = slots[rd_ptr];

always_ff @(posedge Clk) begin
	if (wr_en)
		slots[wr_ptr] <= sample;
end

always_ff @(posedge Clk or negedge arst_n) begin
	if (!arst_n) begin
		rd_ptr <= 1'b0;
		wr_ptr <= 1'b0;
		count <= 2'd0;
	end else begin
		if (wr_en)
			wr_ptr <= !wr_ptr;
		if (rd_en)
			rd_ptr <= !rd_ptr;
		count <= count + {1'b0, wr_en} - {1'b0, rd_en};
	end
end

// write when full or read when empty would land here.
a_count_legal: assert property (@(posedge Clk) disable iff (!arst_n) count != 2'd3);

// head entry waits for the consumer.
a_held_stable: assert property (@(posedge Clk) disable iff (!arst_n)
	b_valid && !b_ready |=> b_valid && $stable(held));

endmodule

/* hw/ray_assemble.sv */
`timescale 1ns/1ps

module ray_assemble (
	input  logic                 Clk,
	input  logic                 arst_n,
	input  logic                 b_valid,
	output logic                 b_ready,
	input  trig_pkg::trig_sample held,
	output logic                 ray_valid,
	input  logic                 ray_ready,
	output fixed_pkg::ray_vec    ray
);

// sign-magnitude word to 32.32.
function automatic fixed_pkg::fixed_real expand(input trig_pkg::table_word w);
	fixed_pkg::fixed_real mag;
	mag = fixed_pkg::fixed_real'(w[14:0]) << trig_pkg::table_shift;
	return w[15] ? -mag : mag;
endfunction

function automatic fixed_pkg::fixed_real wgt_mean(input fixed_pkg::fixed_real low,
		input fixed_pkg::fixed_real high, input trig_pkg::weight_t w);
	fixed_pkg::fixed_real low4;
	fixed_pkg::fixed_real high4;
	fixed_pkg::fixed_real low2;
	fixed_pkg::fixed_real high2;
	low4 = low >>> 2;
	high4 = high >>> 2;
	low2 = low >>> 1;
	high2 = high >>> 1;
	case (w)
		2'd0: return low;
		2'd1: return low4 + low4 + low4 + high4;
		2'd2: return low2 + high2;
		default: return low4 + high4 + high4 + high4;
	endcase
endfunction

function automatic fixed_pkg::fixed_real mul(input fixed_pkg::fixed_real a,
		input fixed_pkg::fixed_real b);
	logic signed [127:0] prod;
	prod = 128'(a) * 128'(b);
	prod = prod >>> fixed_pkg::frac_shift; // back to 32.32.
	return prod[63:0];
endfunction

fixed_pkg::fixed_real sin_t;
fixed_pkg::fixed_real cos_t;
fixed_pkg::fixed_real sin_p;
fixed_pkg::fixed_real cos_p;

assign sin_t = wgt_mean(expand(held.sin_t0), expand(held.sin_t1), held.w_theta);
assign cos_t = wgt_mean(expand(held.cos_t0), expand(held.cos_t1), held.w_theta);
assign sin_p = wgt_mean(expand(held.sin_p0), expand(held.sin_p1), held.w_phi);
assign cos_p = wgt_mean(expand(held.cos_p0), expand(held.cos_p1), held.w_phi);

assign b_ready = !ray_valid || ray_ready;

always_ff @(posedge Clk or negedge arst_n) begin
	if (!arst_n)
		ray_valid <= 1'b0;
	else if (b_ready)
		ray_valid <= b_valid;
end

always_ff @(posedge Clk) begin
	if (b_valid && b_ready)
		ray <= {mul(sin_t, cos_p), mul(sin_t, sin_p), cos_t}; // z, y, x.
end

a_ray_hold: assert property (@(posedge Clk) disable iff (!arst_n)
	ray_valid && !ray_ready |=> ray_valid && $stable(ray));

endmodule

/* hw/ray_gen.sv */
`timescale 1ns/1ps

module ray_gen (
	input  logic                 Clk,
	input  logic                 arst_n,
	input  logic                 in_valid,
	output logic                 in_ready,
	input  fixed_pkg::fixed_real theta,
	input  fixed_pkg::fixed_real phi,
	output logic                 ray_valid,
	input  logic                 ray_ready,
	output fixed_pkg::ray_vec    ray
);

logic s_valid;
logic s_ready;
logic b_valid;
logic b_ready;
trig_pkg::trig_sample sample;
trig_pkg::trig_sample held;

angle_lookup u_angle_lookup (
	.Clk(Clk),
	.arst_n(arst_n),
	.in_valid(in_valid),
	.in_ready(in_ready),
	.theta(theta),
	.phi(phi),
	.s_valid(s_valid),
	.s_ready(s_ready),
	.sample(sample)
);

sample_buffer u_sample_buffer (
	.Clk(Clk),
	.arst_n(arst_n),
	.s_valid(s_valid),
	.s_ready(s_ready),
	.sample(sample),
	.b_valid(b_valid),
	.b_ready(b_ready),
	.held(held)
);

ray_assemble u_ray_assemble (
	.Clk(Clk),
	.arst_n(arst_n),
	.b_valid(b_valid),
	.b_ready(b_ready),
	.held(held),
	.ray_valid(ray_valid),
	.ray_ready(ray_ready),
	.ray(ray)
);

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic arst_n
);

initial begin
	clk = 1'b0;
	forever #20 clk = !clk; // 40 ns period.
end

initial begin
	arst_n = 1'b0;
	repeat (5) @(posedge clk);
	arst_n <= 1'b1;
end

endmodule

/* dv/ray_gen_tb.sv */
`timescale 1ns/1ps

module ray_gen_tb;

localparam int n_requests = 360 + 40 + 91 + 200;
localparam int depth = 1024;

logic Clk;
logic arst_n;
logic in_valid;
logic in_ready;
fixed_pkg::fixed_real theta;
fixed_pkg::fixed_real phi;
logic ray_valid;
logic ray_ready = 1'b1;
fixed_pkg::ray_vec ray;

int stim_seed = 32'hbfdb;
int ready_seed = 32'hbfdb;
int sine_tab [91];
fixed_pkg::ray_vec exp_mem [depth]; // expected rays in request order.
int acc_cyc [depth];
logic timed_mem [depth];
fixed_pkg::ray_vec pend_exp;
logic timed_phase = 1'b1;
logic toggle_ready = 1'b0;
int wr_cnt = 0;
int rd_cnt = 0;
int cyc = 0;
fixed_pkg::ray_vec exp_head;
int head_cyc;
logic head_timed;

tb_clock u_tb_clock (.clk(Clk), .arst_n(arst_n));

ray_gen u_ray_gen (
	.Clk(Clk),
	.arst_n(arst_n),
	.in_valid(in_valid),
	.in_ready(in_ready),
	.theta(theta),
	.phi(phi),
	.ray_valid(ray_valid),
	.ray_ready(ray_ready),
	.ray(ray)
);

assign exp_head = exp_mem[rd_cnt % depth];
assign head_cyc = acc_cyc[rd_cnt % depth];
assign head_timed = timed_mem[rd_cnt % depth];

function automatic fixed_pkg::fixed_real deg_sin(input int d);
	longint mag;
	if (d <= 90)
		mag = longint'(sine_tab[d]);
	else if (d <= 180)
		mag = longint'(sine_tab[180 - d]);
	else if (d <= 270)
		mag = -longint'(sine_tab[d - 180]);
	else
		mag = -longint'(sine_tab[360 - d]);
	return mag <<< 18; // Q1.14 into 32.32.
endfunction

// weighted mean of degree d and the next one.
function automatic fixed_pkg::fixed_real trig_at(input int d, input longint w,
		input logic use_cos);
	fixed_pkg::fixed_real lo;
	fixed_pkg::fixed_real hi;
	lo = use_cos ? deg_sin((d + 90) % 360) : deg_sin(d);
	hi = use_cos ? deg_sin((d + 91) % 360) : deg_sin((d + 1) % 360);
	return (lo * (64'sd4 - w) + hi * w) >>> 2;
endfunction

function automatic fixed_pkg::fixed_real fx_mul(input fixed_pkg::fixed_real a,
		input fixed_pkg::fixed_real b);
	logic signed [127:0] wa;
	logic signed [127:0] wb;
	logic signed [127:0] p;
	wa = a;
	wb = b;
	p = wa * wb;
	return p[95:32];
endfunction

function automatic fixed_pkg::ray_vec model_ray(input fixed_pkg::fixed_real t,
		input fixed_pkg::fixed_real p);
	fixed_pkg::fixed_real st;
	fixed_pkg::fixed_real sp;
	fixed_pkg::fixed_real cp;
	if (t < 0)
		t = t + fixed_pkg::full_turn;
	if (p < 0)
		p = p + fixed_pkg::full_turn;
	st = trig_at(int'(t >>> 32), longint'(t[31:30]), 1'b0);
	sp = trig_at(int'(p >>> 32), longint'(p[31:30]), 1'b0);
	cp = trig_at(int'(p >>> 32), longint'(p[31:30]), 1'b1);
	return {fx_mul(st, cp), fx_mul(st, sp), trig_at(int'(t >>> 32), longint'(t[31:30]), 1'b1)};
endfunction

function automatic fixed_pkg::fixed_real make_angle(input int deg, input int quarters,
		input int fine, input logic neg);
	fixed_pkg::fixed_real a;
	a = (longint'(deg) <<< 32) + (longint'(quarters) <<< 30) +
		longint'(fine & 32'h3fff_ffff);
	return neg ? -a : a;
endfunction

function automatic int pick(input int n);
	return (($random(stim_seed) % n) + n) % n;
endfunction

task automatic stop_run(input string line);
	$display("%s", line);
	$display("TEST FAILED");
	$fatal(1, "stopping at first error");
endtask

task automatic send(input fixed_pkg::fixed_real t, input fixed_pkg::fixed_real p,
		input fixed_pkg::ray_vec e);
	in_valid <= 1'b1;
	theta <= t;
	phi <= p;
	pend_exp <= e;
	@(negedge Clk);
	while (!in_ready)
		@(negedge Clk);
	@(posedge Clk); // accepting edge.
endtask

task automatic drain();
	@(posedge Clk);
	while (rd_cnt != wr_cnt)
		@(posedge Clk);
endtask

always @(posedge Clk) begin
	cyc <= cyc + 1;
	ray_ready <= toggle_ready ? ($random(ready_seed) % 2 != 0) : 1'b1;
	if (arst_n && in_valid && in_ready) begin
		exp_mem[wr_cnt % depth] <= pend_exp;
		acc_cyc[wr_cnt % depth] <= cyc;
		timed_mem[wr_cnt % depth] <= timed_phase;
		wr_cnt <= wr_cnt + 1;
	end
	if (arst_n && ray_valid && ray_ready)
		rd_cnt <= rd_cnt + 1;
end

a_reset_idle: assert property (@(posedge Clk) !arst_n || $rose(arst_n) |->
	!ray_valid && in_ready)
	else stop_run("outputs not idle during or right after reset");

a_ray_value: assert property (@(posedge Clk) disable iff (!arst_n)
	ray_valid && ray_ready |-> ray == exp_head)
	else stop_run($sformatf("MISMATCH at %0t ns: ray %h, expected %h", $time, ray, exp_head));

a_latency: assert property (@(posedge Clk) disable iff (!arst_n)
	ray_valid && ray_ready && head_timed |-> cyc - head_cyc == 3)
	else stop_run($sformatf("MISMATCH at %0t ns: latency %0d cycles, expected 3",
		$time, cyc - head_cyc));

a_pending: assert property (@(posedge Clk) disable iff (!arst_n) ray_valid |-> rd_cnt < wr_cnt)
	else stop_run("a ray came out with no request pending");

a_stalled: assert property (@(posedge Clk) disable iff (!arst_n)
	ray_valid && !ray_ready |=> ray_valid && $stable(ray))
	else stop_run("ray dropped or changed while stalled");

initial begin
	#((n_requests * 100 + 5) * 40);
	stop_run($sformatf("run hung, %0d of %0d rays received", rd_cnt, n_requests));
end

initial begin
	fixed_pkg::fixed_real t;
	fixed_pkg::fixed_real p;
	in_valid = 1'b0;
	theta = '0;
	phi = '0;
	pend_exp = '0;
	for (int d = 0; d <= 90; d++)
		sine_tab[d] = $rtoi($sin(d * 3.14159265358979 / 180.0) * 16384.0 + 0.5);
	wait (arst_n);
	@(posedge Clk);
	for (int d = 0; d < 360; d++) begin
		t = make_angle(d, 0, 0, 1'b0);
		p = make_angle((d * 7 + 3) % 360, 0, 0, 1'b0);
		send(t, p, model_ray(t, p));
	end
	for (int i = 0; i < 40; i++) begin
		t = make_angle(1 + pick(359), pick(4), $random(stim_seed), 1'b1);
		p = make_angle(1 + pick(359), pick(4), $random(stim_seed), 1'b1);
		send(t, p, model_ray(t + fixed_pkg::full_turn, p + fixed_pkg::full_turn));
	end
	for (int i = 0; i < 90; i++) begin
		t = make_angle(pick(360), 1 + i % 3, 0, 1'b0);
		p = make_angle(pick(360), 1 + pick(3), 0, 1'b0);
		send(t, p, model_ray(t, p));
	end
	t = make_angle(359, 3, 0, 1'b0);
	send(t, t, model_ray(t, t)); // 359.75 blends with 0.
	in_valid <= 1'b0;
	drain();
	timed_phase <= 1'b0;
	toggle_ready <= 1'b1;
	for (int i = 0; i < 200; i++) begin
		t = make_angle(pick(360), pick(4), $random(stim_seed), pick(2) == 1);
		p = make_angle(pick(360), pick(4), $random(stim_seed), pick(2) == 1);
		send(t, p, model_ray(t, p));
	end
	in_valid <= 1'b0;
	drain();
	if (wr_cnt != n_requests || rd_cnt != wr_cnt)
		stop_run($sformatf("%0d requests and %0d rays, expected %0d of each",
			wr_cnt, rd_cnt, n_requests));
	else begin
		$display("TEST OK");
		$finish;
	end
end

endmodule

/* ray_gen.f */
+incdir+include
hw/fixed_pkg.sv
hw/trig_pkg.sv
hw/angle_lookup.sv
hw/sample_buffer.sv
hw/ray_assemble.sv
hw/ray_gen.sv
dv/tb_clock.sv
dv/ray_gen_tb.sv

/* build.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module ray_gen_tb -Mdir obj_dir -o ray_gen_sim -f ray_gen.f
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/ray_gen_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0
